/* hw/rs_pkg.sv */
// Shared tag width, null tag and opcode encoding for the reservation station

package rs_pkg;

	// Reorder or physical register tag width
	localparam int RS_TAG_W = 5;

	// All-ones tag marks an empty field and is never given to a producer
	localparam logic [RS_TAG_W-1:0] RS_NULL_TAG = '1;

	// Functional unit opcodes
	// A free slot always holds OP_NOP
	typedef enum logic [2:0] {
		OP_NOP = 3'd0,
		OP_ADD = 3'd1,
		OP_SUB = 3'd2,
		OP_AND = 3'd3,
		OP_OR  = 3'd4,
		OP_XOR = 3'd5,
		OP_SLL = 3'd6,
		OP_MUL = 3'd7
	} rs_op_e;

endpackage

/* hw/rs_entry.sv */
// Reservation station slot holding one instruction with CDB wakeup and same-cycle ready
`timescale 1ns/100ps

module rs_entry
	import rs_pkg::*;
(
	input  logic                clk,
	input  logic                rst,

	input  logic                load_i,
	input  logic                iss_en_i,

	input  logic [RS_TAG_W-1:0] dest_tag_i,
	input  logic [RS_TAG_W-1:0] opa_tag_i,
	input  logic [RS_TAG_W-1:0] opb_tag_i,
	input  logic                opa_rdy_i,
	input  logic                opb_rdy_i,
	input  rs_op_e              op_i,

	input  logic                cdb_vld_i,
	input  logic [RS_TAG_W-1:0] cdb_tag_i,

	output logic                rdy_o,
	output logic                avail_o,
	output rs_op_e              op_o,
	output logic [RS_TAG_W-1:0] dest_tag_o,
	output logic [RS_TAG_W-1:0] opa_tag_o,
	output logic [RS_TAG_W-1:0] opb_tag_o
);

	// Stored slot state
	logic [RS_TAG_W-1:0] dest_tag_r;
	logic [RS_TAG_W-1:0] opa_tag_r;
	logic [RS_TAG_W-1:0] opb_tag_r;
	logic                opa_rdy_r;
	logic                opb_rdy_r;
	rs_op_e              op_r;
	logic                avail_r;

	logic [RS_TAG_W-1:0] dest_tag_nxt;
	logic [RS_TAG_W-1:0] opa_tag_nxt;
	logic [RS_TAG_W-1:0] opb_tag_nxt;
	logic                opa_rdy_nxt;
	logic                opb_rdy_nxt;
	rs_op_e              op_nxt;
	logic                avail_nxt;

	// CDB compare against the tags arriving with a dispatch
	logic opa_hit_new;
	logic opb_hit_new;
	// CDB compare against the tags already held
	logic opa_hit_held;
	logic opb_hit_held;

	assign opa_hit_new  = cdb_vld_i && (cdb_tag_i == opa_tag_i);
	assign opb_hit_new  = cdb_vld_i && (cdb_tag_i == opb_tag_i);
	assign opa_hit_held = cdb_vld_i && (cdb_tag_i == opa_tag_r);
	assign opb_hit_held = cdb_vld_i && (cdb_tag_i == opb_tag_r);

	// Ready in the same cycle as the completing broadcast
	assign rdy_o = !avail_r && (opa_rdy_r || opa_hit_held) && (opb_rdy_r || opb_hit_held);

	assign avail_o    = avail_r;
	assign op_o       = op_r;
	assign dest_tag_o = dest_tag_r;
	assign opa_tag_o  = opa_tag_r;
	assign opb_tag_o  = opb_tag_r;

	always_comb begin
		dest_tag_nxt = dest_tag_r;
		opa_tag_nxt  = opa_tag_r;
		opb_tag_nxt  = opb_tag_r;
		op_nxt       = op_r;
		avail_nxt    = avail_r;
		// Held operands keep listening to the CDB, also while issue is stalled
		opa_rdy_nxt  = opa_rdy_r || (!avail_r && opa_hit_held);
		opb_rdy_nxt  = opb_rdy_r || (!avail_r && opb_hit_held);

		if (iss_en_i) begin
			// Slot goes back to the free state
			dest_tag_nxt = RS_NULL_TAG;
			opa_tag_nxt  = RS_NULL_TAG;
			opb_tag_nxt  = RS_NULL_TAG;
			op_nxt       = OP_NOP;
			avail_nxt    = 1'b1;
			opa_rdy_nxt  = 1'b0;
			opb_rdy_nxt  = 1'b0;
		end else if (load_i) begin
			dest_tag_nxt = dest_tag_i;
			opa_tag_nxt  = opa_tag_i;
			opb_tag_nxt  = opb_tag_i;
			op_nxt       = op_i;
			avail_nxt    = 1'b0;
			opa_rdy_nxt  = opa_rdy_i || opa_hit_new;
			opb_rdy_nxt  = opb_rdy_i || opb_hit_new;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			dest_tag_r <= RS_NULL_TAG;
			opa_tag_r  <= RS_NULL_TAG;
			opb_tag_r  <= RS_NULL_TAG;
			opa_rdy_r  <= 1'b0;
			opb_rdy_r  <= 1'b0;
			op_r       <= OP_NOP;
			avail_r    <= 1'b1;
		end else begin
			dest_tag_r <= dest_tag_nxt;
			opa_tag_r  <= opa_tag_nxt;
			opb_tag_r  <= opb_tag_nxt;
			opa_rdy_r  <= opa_rdy_nxt;
			opb_rdy_r  <= opb_rdy_nxt;
			op_r       <= op_nxt;
			avail_r    <= avail_nxt;
		end
	end

endmodule

/* hw/rs_alloc.sv */
// Dispatch allocator that loads the lowest free slot and flags a full station
`timescale 1ns/100ps

module rs_alloc #(
	parameter int NUM_ENTRIES = 4
) (
	input  logic                   dispatch_vld_i,
	input  logic [NUM_ENTRIES-1:0] avail_i,
	output logic [NUM_ENTRIES-1:0] load_o,
	output logic                   full_o
);

	// One-hot marker of the lowest free slot
	logic [NUM_ENTRIES-1:0] first_free;
	logic                   found;

	// Fixed priority search from slot 0 upwards
	always_comb begin
		first_free = '0;
		found      = 1'b0;
		for (int i = 0; i < NUM_ENTRIES; i++) begin
			if (avail_i[i] && !found) begin
				first_free[i] = 1'b1;
				found         = 1'b1;
			end
		end
	end

	// No free slot at all
	assign full_o = ~|avail_i;

	// A slot freed by issue this cycle is not yet visible in avail_i
	// so it is only offered again on the following cycle
	assign load_o = dispatch_vld_i ? first_free : '0;

endmodule

/* hw/rs_issue_select.sv */
// Issue selector that sends the lowest ready slot to the functional unit
`timescale 1ns/100ps

module rs_issue_select
	import rs_pkg::*;
#(
	parameter int NUM_ENTRIES = 4
) (
	input  logic [NUM_ENTRIES-1:0] rdy_i,
	input  logic                   fu_busy_i,

	// Stored fields of every slot
	input  rs_op_e                 op_i       [NUM_ENTRIES],
	input  logic [RS_TAG_W-1:0]    dest_tag_i [NUM_ENTRIES],
	input  logic [RS_TAG_W-1:0]    opa_tag_i  [NUM_ENTRIES],
	input  logic [RS_TAG_W-1:0]    opb_tag_i  [NUM_ENTRIES],

	output logic [NUM_ENTRIES-1:0] iss_en_o,
	output logic                   issue_vld_o,
	output rs_op_e                 issue_op_o,
	output logic [RS_TAG_W-1:0]    issue_dest_tag_o,
	output logic [RS_TAG_W-1:0]    issue_opa_tag_o,
	output logic [RS_TAG_W-1:0]    issue_opb_tag_o
);

	// Set once a slot has been chosen in the scan
	logic picked;

	always_comb begin
		picked           = 1'b0;
		iss_en_o         = '0;
		issue_op_o       = OP_NOP;
		issue_dest_tag_o = RS_NULL_TAG;
		issue_opa_tag_o  = RS_NULL_TAG;
		issue_opb_tag_o  = RS_NULL_TAG;

		// Busy unit holds every slot in place
		if (!fu_busy_i) begin
			for (int i = 0; i < NUM_ENTRIES; i++) begin
				if (rdy_i[i] && !picked) begin
					picked           = 1'b1;
					iss_en_o[i]      = 1'b1;
					issue_op_o       = op_i[i];
					issue_dest_tag_o = dest_tag_i[i];
					issue_opa_tag_o  = opa_tag_i[i];
					issue_opb_tag_o  = opb_tag_i[i];
				end
			end
		end
	end

	// The unit takes whatever is presented, there is no accept
	assign issue_vld_o = picked;

endmodule

/* hw/rs_top.sv */
// Reservation station for one functional unit built from slots, allocator and issue selector
`timescale 1ns/100ps

module rs_top
	import rs_pkg::*;
#(
	parameter int NUM_ENTRIES = 4
) (
	input  logic                clk,
	input  logic                rst,

	// Dispatch port
	input  logic                dispatch_vld_i,
	input  rs_op_e              dispatch_op_i,
	input  logic [RS_TAG_W-1:0] dispatch_dest_tag_i,
	input  logic [RS_TAG_W-1:0] dispatch_opa_tag_i,
	input  logic                dispatch_opa_rdy_i,
	input  logic [RS_TAG_W-1:0] dispatch_opb_tag_i,
	input  logic                dispatch_opb_rdy_i,

	// Common data bus
	input  logic                cdb_vld_i,
	input  logic [RS_TAG_W-1:0] cdb_tag_i,

	input  logic                fu_busy_i,

	output logic                full_o,

	// Issue port
	output logic                issue_vld_o,
	output rs_op_e              issue_op_o,
	output logic [RS_TAG_W-1:0] issue_dest_tag_o,
	output logic [RS_TAG_W-1:0] issue_opa_tag_o,
	output logic [RS_TAG_W-1:0] issue_opb_tag_o
);

	// Per-slot status and strobes
	logic [NUM_ENTRIES-1:0] slot_avail;
	logic [NUM_ENTRIES-1:0] slot_rdy;
	logic [NUM_ENTRIES-1:0] slot_load;
	logic [NUM_ENTRIES-1:0] slot_iss_en;

	// Per-slot stored fields
	rs_op_e                 slot_op       [NUM_ENTRIES];
	logic [RS_TAG_W-1:0]    slot_dest_tag [NUM_ENTRIES];
	logic [RS_TAG_W-1:0]    slot_opa_tag  [NUM_ENTRIES];
	logic [RS_TAG_W-1:0]    slot_opb_tag  [NUM_ENTRIES];

	// Dispatch fields and CDB fan out to every slot
	for (genvar i = 0; i < NUM_ENTRIES; i++) begin : g_slot
		rs_entry u_entry (
			.clk        (clk),
			.rst        (rst),
			.load_i     (slot_load[i]),
			.iss_en_i   (slot_iss_en[i]),
			.dest_tag_i (dispatch_dest_tag_i),
			.opa_tag_i  (dispatch_opa_tag_i),
			.opb_tag_i  (dispatch_opb_tag_i),
			.opa_rdy_i  (dispatch_opa_rdy_i),
			.opb_rdy_i  (dispatch_opb_rdy_i),
			.op_i       (dispatch_op_i),
			.cdb_vld_i  (cdb_vld_i),
			.cdb_tag_i  (cdb_tag_i),
			.rdy_o      (slot_rdy[i]),
			.avail_o    (slot_avail[i]),
			.op_o       (slot_op[i]),
			.dest_tag_o (slot_dest_tag[i]),
			.opa_tag_o  (slot_opa_tag[i]),
			.opb_tag_o  (slot_opb_tag[i])
		);
	end

	rs_alloc #(
		.NUM_ENTRIES (NUM_ENTRIES)
	) u_alloc (
		.dispatch_vld_i (dispatch_vld_i),
		.avail_i        (slot_avail),
		.load_o         (slot_load),
		.full_o         (full_o)
	);

	rs_issue_select #(
		.NUM_ENTRIES (NUM_ENTRIES)
	) u_issue_select (
		.rdy_i            (slot_rdy),
		.fu_busy_i        (fu_busy_i),
		.op_i             (slot_op),
		.dest_tag_i       (slot_dest_tag),
		.opa_tag_i        (slot_opa_tag),
		.opb_tag_i        (slot_opb_tag),
		.iss_en_o         (slot_iss_en),
		.issue_vld_o      (issue_vld_o),
		.issue_op_o       (issue_op_o),
		.issue_dest_tag_o (issue_dest_tag_o),
		.issue_opa_tag_o  (issue_opa_tag_o),
		.issue_opb_tag_o  (issue_opb_tag_o)
	);

endmodule

/* verification/rs_properties.sv */
// Concurrent checks on the reservation station top-level ports
`timescale 1ns/100ps

module rs_properties
	import rs_pkg::*;
(
	input logic                clk,
	input logic                rst,
	input logic                fu_busy_i,
	input logic                dispatch_vld_i,
	input logic                full_o,
	input logic                issue_vld_o,
	input logic [RS_TAG_W-1:0] issue_dest_tag_o
);

	// A busy unit takes nothing
	assert property (@(posedge clk) disable iff (rst) fu_busy_i |-> !issue_vld_o)
		else $error("issue while functional unit busy");

	// Source must hold off while the station is full
	assert property (@(posedge clk) disable iff (rst) full_o |-> !dispatch_vld_i)
		else $error("dispatch while station full");

	assert property (@(posedge clk) disable iff (rst)
		issue_vld_o |-> issue_dest_tag_o != RS_NULL_TAG)
		else $error("issue carries the null destination tag");

	// First cycle out of reset
	assert property (@(posedge clk) $fell(rst) |-> !issue_vld_o && !full_o)
		else $error("issue or full high right after reset");

endmodule

bind rs_top rs_properties u_properties (
	.clk              (clk),
	.rst              (rst),
	.fu_busy_i        (fu_busy_i),
	.dispatch_vld_i   (dispatch_vld_i),
	.full_o           (full_o),
	.issue_vld_o      (issue_vld_o),
	.issue_dest_tag_o (issue_dest_tag_o)
);

/* verification/rs_tb.sv */
// Testbench for the reservation station with a slot-level reference model and cycle checks
`timescale 1ns/100ps

module rs_tb
	import rs_pkg::*;
();

	localparam int NUM = 4;

	logic                clk;
	logic                rst;
	logic                dispatch_vld_i;
	rs_op_e              dispatch_op_i;
	logic [RS_TAG_W-1:0] dispatch_dest_tag_i;
	logic [RS_TAG_W-1:0] dispatch_opa_tag_i;
	logic                dispatch_opa_rdy_i;
	logic [RS_TAG_W-1:0] dispatch_opb_tag_i;
	logic                dispatch_opb_rdy_i;
	logic                cdb_vld_i;
	logic [RS_TAG_W-1:0] cdb_tag_i;
	logic                fu_busy_i;
	logic                full_o;
	logic                issue_vld_o;
	rs_op_e              issue_op_o;
	logic [RS_TAG_W-1:0] issue_dest_tag_o;
	logic [RS_TAG_W-1:0] issue_opa_tag_o;
	logic [RS_TAG_W-1:0] issue_opb_tag_o;

	// Reference slot state
	logic                m_avail   [NUM];
	logic [RS_TAG_W-1:0] m_dest    [NUM];
	logic [RS_TAG_W-1:0] m_opa     [NUM];
	logic [RS_TAG_W-1:0] m_opb     [NUM];
	logic                m_opa_rdy [NUM];
	logic                m_opb_rdy [NUM];
	rs_op_e              m_op      [NUM];

	// Expected outputs for the current cycle
	logic                e_vld;
	rs_op_e              e_op;
	logic [RS_TAG_W-1:0] e_dest;
	logic [RS_TAG_W-1:0] e_opa;
	logic [RS_TAG_W-1:0] e_opb;
	logic                e_full;
	int                  iss_slot;
	int                  load_slot;

	int                  err_count;
	int                  pass_count;
	int                  fail_count;
	int                  dispatched_cnt [32];
	int                  issued_cnt     [32];
	logic [RS_TAG_W-1:0] issue_log [$];
	int                  seed;

	rs_top #(
		.NUM_ENTRIES (NUM)
	) uut (
		.clk                 (clk),
		.rst                 (rst),
		.dispatch_vld_i      (dispatch_vld_i),
		.dispatch_op_i       (dispatch_op_i),
		.dispatch_dest_tag_i (dispatch_dest_tag_i),
		.dispatch_opa_tag_i  (dispatch_opa_tag_i),
		.dispatch_opa_rdy_i  (dispatch_opa_rdy_i),
		.dispatch_opb_tag_i  (dispatch_opb_tag_i),
		.dispatch_opb_rdy_i  (dispatch_opb_rdy_i),
		.cdb_vld_i           (cdb_vld_i),
		.cdb_tag_i           (cdb_tag_i),
		.fu_busy_i           (fu_busy_i),
		.full_o              (full_o),
		.issue_vld_o         (issue_vld_o),
		.issue_op_o          (issue_op_o),
		.issue_dest_tag_o    (issue_dest_tag_o),
		.issue_opa_tag_o     (issue_opa_tag_o),
		.issue_opb_tag_o     (issue_opb_tag_o)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// Lowest ready slot wins unless the unit is busy, CDB counts in the same cycle
	function automatic void expected_outputs(output logic vld, output rs_op_e op,
		output logic [RS_TAG_W-1:0] dest, output logic [RS_TAG_W-1:0] opa,
		output logic [RS_TAG_W-1:0] opb, output logic full, output int slot);
		logic ra;
		logic rb;
		vld  = 1'b0;
		op   = OP_NOP;
		dest = RS_NULL_TAG;
		opa  = RS_NULL_TAG;
		opb  = RS_NULL_TAG;
		full = 1'b1;
		slot = -1;
		for (int i = 0; i < NUM; i++) begin
			ra = m_opa_rdy[i] || (cdb_vld_i && cdb_tag_i == m_opa[i]);
			rb = m_opb_rdy[i] || (cdb_vld_i && cdb_tag_i == m_opb[i]);
			if (m_avail[i])
				full = 1'b0;
			if (!fu_busy_i && !vld && !m_avail[i] && ra && rb) begin
				vld  = 1'b1;
				slot = i;
				op   = m_op[i];
				dest = m_dest[i];
				opa  = m_opa[i];
				opb  = m_opb[i];
			end
		end
	endfunction

	function automatic logic model_empty();
		logic empty;
		empty = 1'b1;
		for (int i = 0; i < NUM; i++)
			if (!m_avail[i])
				empty = 1'b0;
		return empty;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		$display("ERROR %s expected %0h got %0h at %0t", name, exp, act, $time);
		err_count++;
	endtask

	// Valid issue carrying the given destination tag
	task automatic check_issue(input logic [RS_TAG_W-1:0] tag);
		if (issue_vld_o !== 1'b1)
			report_mismatch("issue_vld_o", 1, issue_vld_o);
		if (issue_dest_tag_o !== tag)
			report_mismatch("issue_dest_tag_o", tag, issue_dest_tag_o);
	endtask

	// Compare against the model, then advance it by one edge
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM; i++) begin
				m_avail[i]   = 1'b1;
				m_dest[i]    = RS_NULL_TAG;
				m_opa[i]     = RS_NULL_TAG;
				m_opb[i]     = RS_NULL_TAG;
				m_opa_rdy[i] = 1'b0;
				m_opb_rdy[i] = 1'b0;
				m_op[i]      = OP_NOP;
			end
		end else begin
			expected_outputs(e_vld, e_op, e_dest, e_opa, e_opb, e_full, iss_slot);
			if (issue_vld_o !== e_vld)
				report_mismatch("issue_vld_o", e_vld, issue_vld_o);
			if (issue_op_o !== e_op)
				report_mismatch("issue_op_o", e_op, issue_op_o);
			if (issue_dest_tag_o !== e_dest)
				report_mismatch("issue_dest_tag_o", e_dest, issue_dest_tag_o);
			if (issue_opa_tag_o !== e_opa)
				report_mismatch("issue_opa_tag_o", e_opa, issue_opa_tag_o);
			if (issue_opb_tag_o !== e_opb)
				report_mismatch("issue_opb_tag_o", e_opb, issue_opb_tag_o);
			if (full_o !== e_full)
				report_mismatch("full_o", e_full, full_o);

			if (issue_vld_o === 1'b1) begin
				issued_cnt[issue_dest_tag_o]++;
				issue_log.push_back(issue_dest_tag_o);
			end

			load_slot = -1;
			if (dispatch_vld_i) begin
				dispatched_cnt[dispatch_dest_tag_i]++;
				for (int i = NUM - 1; i >= 0; i--)
					if (m_avail[i])
						load_slot = i;
			end

			for (int i = 0; i < NUM; i++) begin
				if (i == iss_slot) begin
					m_avail[i]   = 1'b1;
					m_dest[i]    = RS_NULL_TAG;
					m_opa[i]     = RS_NULL_TAG;
					m_opb[i]     = RS_NULL_TAG;
					m_opa_rdy[i] = 1'b0;
					m_opb_rdy[i] = 1'b0;
					m_op[i]      = OP_NOP;
				end else if (i == load_slot) begin
					m_avail[i]   = 1'b0;
					m_dest[i]    = dispatch_dest_tag_i;
					m_opa[i]     = dispatch_opa_tag_i;
					m_opb[i]     = dispatch_opb_tag_i;
					m_op[i]      = dispatch_op_i;
					m_opa_rdy[i] = dispatch_opa_rdy_i ||
						(cdb_vld_i && cdb_tag_i == dispatch_opa_tag_i);
					m_opb_rdy[i] = dispatch_opb_rdy_i ||
						(cdb_vld_i && cdb_tag_i == dispatch_opb_tag_i);
				end else if (!m_avail[i]) begin
					m_opa_rdy[i] = m_opa_rdy[i] || (cdb_vld_i && cdb_tag_i == m_opa[i]);
					m_opb_rdy[i] = m_opb_rdy[i] || (cdb_vld_i && cdb_tag_i == m_opb[i]);
				end
			end
		end
	end

	task automatic set_dispatch(input rs_op_e op, input logic [RS_TAG_W-1:0] dest,
		input logic [RS_TAG_W-1:0] a, input logic ar,
		input logic [RS_TAG_W-1:0] b, input logic br);
		dispatch_vld_i      = 1'b1;
		dispatch_op_i       = op;
		dispatch_dest_tag_i = dest;
		dispatch_opa_tag_i  = a;
		dispatch_opa_rdy_i  = ar;
		dispatch_opb_tag_i  = b;
		dispatch_opb_rdy_i  = br;
	endtask

	task automatic set_cdb(input logic vld, input logic [RS_TAG_W-1:0] tag);
		cdb_vld_i = vld;
		cdb_tag_i = tag;
	endtask

	task automatic idle_inputs();
		dispatch_vld_i = 1'b0;
		cdb_vld_i      = 1'b0;
	endtask

	task automatic wait_issued(input logic [RS_TAG_W-1:0] tag, input int limit);
		int cycles;
		cycles = 0;
		while (issued_cnt[tag] == 0 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end
		if (issued_cnt[tag] == 0) begin
			$display("Timed out after %0d cycles waiting for tag %0h to issue", limit, tag);
			err_count++;
		end
	endtask

	// Broadcast every tag in turn until all slots have issued
	task automatic drain(input int limit);
		int cycles;
		cycles = 0;
		@(negedge clk);
		idle_inputs();
		fu_busy_i = 1'b0;
		while (!model_empty() && cycles < limit) begin
			set_cdb(1'b1, RS_TAG_W'(cycles % 31));
			@(negedge clk);
			cycles++;
		end
		idle_inputs();
		if (!model_empty()) begin
			$display("Timed out after %0d cycles waiting for the station to empty", limit);
			err_count++;
		end
	endtask

	task automatic finish_test(input string name, input int errs_before);
		if (err_count == errs_before) begin
			pass_count++;
			$display("test %s: ok", name);
		end else begin
			fail_count++;
			$display("test %s: %0d errors", name, err_count - errs_before);
		end
	endtask

	initial begin
		int errs;
		int r;
		logic [RS_TAG_W-1:0] next_dest;

		err_count  = 0;
		pass_count = 0;
		fail_count = 0;
		seed       = 32'hdd67_1b80;
		for (int t = 0; t < 32; t++) begin
			dispatched_cnt[t] = 0;
			issued_cnt[t]     = 0;
		end
		rst = 1'b1;
		fu_busy_i = 1'b0;
		cdb_tag_i = '0;
		set_dispatch(OP_NOP, '0, '0, 1'b0, '0, 1'b0);
		idle_inputs();
		repeat (2) @(negedge clk);
		rst = 1'b0;

		// Reset state
		errs = err_count;
		@(negedge clk);
		if (full_o !== 1'b0)
			report_mismatch("full_o", 0, full_o);
		if (issue_vld_o !== 1'b0)
			report_mismatch("issue_vld_o", 0, issue_vld_o);
		if (issue_dest_tag_o !== RS_NULL_TAG)
			report_mismatch("issue_dest_tag_o", RS_NULL_TAG, issue_dest_tag_o);
		if (issue_opa_tag_o !== RS_NULL_TAG)
			report_mismatch("issue_opa_tag_o", RS_NULL_TAG, issue_opa_tag_o);
		if (issue_opb_tag_o !== RS_NULL_TAG)
			report_mismatch("issue_opb_tag_o", RS_NULL_TAG, issue_opb_tag_o);
		if (issue_op_o !== OP_NOP)
			report_mismatch("issue_op_o", OP_NOP, issue_op_o);
		finish_test("reset", errs);

		// Back-to-back ready instructions
		errs = err_count;
		issue_log.delete();
		set_dispatch(OP_ADD, 5'd1, 5'd20, 1'b1, 5'd21, 1'b1);
		@(negedge clk);
		set_dispatch(OP_SUB, 5'd2, 5'd22, 1'b1, 5'd23, 1'b1);
		@(negedge clk);
		set_dispatch(OP_AND, 5'd3, 5'd24, 1'b1, 5'd25, 1'b1);
		@(negedge clk);
		set_dispatch(OP_OR, 5'd4, 5'd26, 1'b1, 5'd27, 1'b1);
		@(negedge clk);
		idle_inputs();
		wait_issued(5'd4, 20);
		for (int k = 0; k < 4; k++)
			if (issue_log.size() <= k || issue_log[k] !== RS_TAG_W'(k + 1))
				report_mismatch("issue_dest_tag_o", k + 1,
					issue_log.size() > k ? issue_log[k] : '1);
		finish_test("ready dispatch", errs);

		// CDB wakeup, shared tag and lowest-index pick
		errs = err_count;
		set_dispatch(OP_XOR, 5'd5, 5'd10, 1'b0, 5'd10, 1'b0);
		@(negedge clk);
		set_dispatch(OP_SLL, 5'd6, 5'd11, 1'b0, 5'd0, 1'b1);
		@(negedge clk);
		set_dispatch(OP_MUL, 5'd7, 5'd11, 1'b0, 5'd11, 1'b0);
		@(negedge clk);
		idle_inputs();
		@(negedge clk);
		set_cdb(1'b1, 5'd10);
		@(posedge clk);
		check_issue(5'd5);
		@(negedge clk);
		set_cdb(1'b1, 5'd11);
		@(posedge clk);
		check_issue(5'd6);
		@(negedge clk);
		idle_inputs();
		@(posedge clk);
		check_issue(5'd7);
		drain(100);
		finish_test("cdb wakeup", errs);

		// Broadcast in the dispatch cycle
		errs = err_count;
		@(negedge clk);
		set_dispatch(OP_ADD, 5'd8, 5'd12, 1'b0, 5'd13, 1'b1);
		set_cdb(1'b1, 5'd12);
		@(negedge clk);
		idle_inputs();
		@(posedge clk);
		check_issue(5'd8);
		drain(100);
		finish_test("dispatch wakeup", errs);

		// Fill the station, wake slot 1
		errs = err_count;
		@(negedge clk);
		for (int k = 0; k < 4; k++) begin
			set_dispatch(OP_SUB, RS_TAG_W'(14 + k), RS_TAG_W'(24 + k), 1'b0, 5'd0, 1'b1);
			@(negedge clk);
		end
		idle_inputs();
		set_cdb(1'b1, 5'd25);
		@(posedge clk);
		if (full_o !== 1'b1)
			report_mismatch("full_o", 1, full_o);
		check_issue(5'd15);
		@(negedge clk);
		idle_inputs();
		@(posedge clk);
		if (full_o !== 1'b0)
			report_mismatch("full_o", 0, full_o);
		drain(100);
		finish_test("full", errs);

		// Random traffic checked cycle by cycle against the model
		errs = err_count;
		next_dest = '0;
		for (int c = 0; c < 400; c++) begin
			@(negedge clk);
			r = $random(seed);
			idle_inputs();
			if (!full_o && r[0]) begin
				set_dispatch(rs_op_e'(r[3:1]), next_dest, RS_TAG_W'(r[6:4]), r[7],
					RS_TAG_W'(r[10:8]), r[11]);
				next_dest = (next_dest == 5'd30) ? 5'd0 : next_dest + 5'd1;
			end
			set_cdb(r[12] | r[13], RS_TAG_W'(r[18:16]));
			fu_busy_i = (r[20:19] == 2'b00);
		end
		drain(200);
		for (int t = 0; t < 32; t++)
			if (dispatched_cnt[t] != issued_cnt[t]) begin
				$display("Tag %0h was dispatched %0d times but issued %0d times", t,
					dispatched_cnt[t], issued_cnt[t]);
				err_count++;
			end
		finish_test("random", errs);

		$display("%0d passed, %0d failed, %0d errors", pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

/* tb.f */
hw/rs_pkg.sv
hw/rs_entry.sv
hw/rs_alloc.sv
hw/rs_issue_select.sv
hw/rs_top.sv
verification/rs_properties.sv
verification/rs_tb.sv
